/* src/proc_settings.svh */
/* sizes shared by the four-stage core
   include wherever a word width, register count or store depth is needed */

`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// ----------------------------------------------------------------------
// datapath
// ----------------------------------------------------------------------

// data word width
`define PROC_WORD_W 16

// architectural registers, r0 reads as zero
`define PROC_NREGS 8

// ----------------------------------------------------------------------
// instruction store
// ----------------------------------------------------------------------

// instruction words, also sets the pc width
`define PROC_IMEM_DEPTH 32

`endif

/* src/proc_pkg.sv */
/* types, opcode encoding and field helpers shared by every stage
   field use: addi rd,rs,imm7  add/sub/and rd,rs,rt  bne/beq rd,rs,imm7  mfc rd  mtc rs */

`include "proc_settings.svh"

package proc_pkg;

  typedef logic [`PROC_WORD_W-1:0] word_t;
  typedef logic [15:0] inst_t;
  typedef logic [$clog2(`PROC_NREGS)-1:0] reg_addr_t;
  typedef logic [$clog2(`PROC_IMEM_DEPTH)-1:0] pc_t;

  // bits 15..13, all-zero word is addi r0, r0, 0 (the nop)
  typedef enum logic [2:0] {
    OP_ADDI = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_AND  = 3'd3,
    OP_BNE  = 3'd4,
    OP_BEQ  = 3'd5,
    OP_MFC  = 3'd6,
    OP_MTC  = 3'd7
  } opcode_t;

  // where a bypassed operand comes from
  typedef enum logic [1:0] {BYP_NONE, BYP_X, BYP_W} stage_t;

  function automatic opcode_t inst_op(inst_t inst);
    return opcode_t'(inst[15:13]);
  endfunction

  function automatic reg_addr_t inst_rd(inst_t inst);
    return inst[12:10];
  endfunction

  function automatic reg_addr_t inst_rs(inst_t inst);
    return inst[9:7];
  endfunction

  function automatic reg_addr_t inst_rt(inst_t inst);
    return inst[6:4];
  endfunction

  // signed imm7, widened to a data word
  function automatic word_t sext_imm(inst_t inst);
    return {{(`PROC_WORD_W-7){inst[6]}}, inst[6:0]};
  endfunction

  // ops that leave a result in rd
  function automatic logic writes_rd(opcode_t op);
    return op inside {OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_MFC};
  endfunction

endpackage

/* src/proc_fetch.sv */
`timescale 1ns/10ps
/* fetch stage: pc, instruction store and the fetch-to-decode register
   the store is filled through the load port while rst is held */

`include "proc_settings.svh"

module proc_fetch (
  input  logic            clk,
  input  logic            rst,
  input  logic            imem_wen,
  input  proc_pkg::pc_t   imem_waddr,
  input  proc_pkg::inst_t imem_wdata,
  input  logic            redirect,
  input  proc_pkg::pc_t   redirect_pc,
  input  logic            stall,
  output proc_pkg::inst_t inst_d,
  output proc_pkg::pc_t   pc_d,
  output logic            val_d
);
  import proc_pkg::*;

  // address of the next word to fetch
  pc_t   pc_f;
  inst_t imem [`PROC_IMEM_DEPTH];

  // ----------------------------------------------------------------------
  // instruction store
  // ----------------------------------------------------------------------

  // load port only works with the core held
  always_ff @(posedge clk) begin
    if (rst && imem_wen) begin
      imem[imem_waddr] <= imem_wdata;
    end
  end

  // ----------------------------------------------------------------------
  // pc
  // ----------------------------------------------------------------------

  // redirect wins over any stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_f <= '0;
    end else if (redirect) begin
      pc_f <= redirect_pc;
    end else if (!stall) begin
      pc_f <= pc_f + pc_t'(1);
    end
  end

  // ----------------------------------------------------------------------
  // fetch -> decode register
  // ----------------------------------------------------------------------

  // redirect drops the word now in decode
  always_ff @(posedge clk) begin
    if (rst) begin
      val_d <= 1'b0;
    end else if (redirect) begin
      val_d <= 1'b0;
    end else if (!stall) begin
      val_d <= 1'b1;
    end
  end

  // payload follows the pc, hold while stalled
  always_ff @(posedge clk) begin
    if (!stall) begin
      inst_d <= imem[pc_f];
      pc_d   <= pc_f;
    end
  end

  // manager must not touch the store once the core runs
  a_load_in_reset: assert property (@(posedge clk) imem_wen |-> rst)
    else $error("imem write outside reset");

endmodule

/* src/proc_decode.sv */
`timescale 1ns/10ps
/* decode stage: register file, operand bypass, mfc handshake and the
   decode-to-execute register; execute result beats writeback in the bypass */

`include "proc_settings.svh"

module proc_decode (
  input  logic                clk,
  input  logic                rst,
  input  proc_pkg::inst_t     inst_d,
  input  proc_pkg::pc_t       pc_d,
  input  logic                val_d,
  input  proc_pkg::word_t     alu_x,
  input  logic                rf_wen,
  input  proc_pkg::reg_addr_t rf_waddr,
  input  proc_pkg::word_t     rf_wdata,
  input  logic                squash,
  input  logic                stall_w,
  input  proc_pkg::word_t     from_mngr_msg,
  input  logic                from_mngr_val,
  output logic                from_mngr_rdy,
  output logic                stall_d,
  output proc_pkg::word_t     op_a_x,
  output proc_pkg::word_t     op_b_x,
  output proc_pkg::inst_t     inst_x,
  output proc_pkg::pc_t       pc_x,
  output logic                val_x
);
  import proc_pkg::*;

  word_t     rf [`PROC_NREGS];
  opcode_t   op_d;
  reg_addr_t rs_d;
  reg_addr_t rb_d;
  reg_addr_t rd_x;
  logic      x_wr;
  logic      mfc_d;
  stage_t    sel_a;
  stage_t    sel_b;
  word_t     rs_rf;
  word_t     rb_rf;
  word_t     op_a_d;
  word_t     op_b_d;

  // nearest producer of register r, r0 never matches
  function automatic stage_t byp_src(reg_addr_t r, logic x_en, reg_addr_t x_rd,
                                     logic w_en, reg_addr_t w_rd);
    if (x_en && x_rd == r) begin
      return BYP_X;
    end
    if (w_en && w_rd == r) begin
      return BYP_W;
    end
    return BYP_NONE;
  endfunction

  function automatic word_t pick(stage_t sel, word_t from_x, word_t from_w, word_t from_rf);
    case (sel)
      BYP_X:   return from_x;
      BYP_W:   return from_w;
      default: return from_rf;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // register file
  // ----------------------------------------------------------------------

  // written by writeback, which already drops r0
  always_ff @(posedge clk) begin
    if (rf_wen) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  assign op_d = inst_op(inst_d);
  assign rs_d = inst_rs(inst_d);
  // branches compare rd with rs
  assign rb_d = (op_d inside {OP_BNE, OP_BEQ}) ? inst_rd(inst_d) : inst_rt(inst_d);

  assign rs_rf = (rs_d == '0) ? '0 : rf[rs_d];
  assign rb_rf = (rb_d == '0) ? '0 : rf[rb_d];

  // ----------------------------------------------------------------------
  // bypass
  // ----------------------------------------------------------------------

  assign rd_x  = inst_rd(inst_x);
  assign x_wr  = val_x && writes_rd(inst_op(inst_x)) && rd_x != '0;
  assign sel_a = byp_src(rs_d, x_wr, rd_x, rf_wen, rf_waddr);
  assign sel_b = byp_src(rb_d, x_wr, rd_x, rf_wen, rf_waddr);

  // mfc takes the manager word, mfc/mtc add zero in execute
  always_comb begin
    op_a_d = pick(sel_a, alu_x, rf_wdata, rs_rf);
    op_b_d = pick(sel_b, alu_x, rf_wdata, rb_rf);
    case (op_d)
      OP_ADDI: op_b_d = sext_imm(inst_d);
      OP_MFC: begin
        op_a_d = from_mngr_msg;
        op_b_d = '0;
      end
      OP_MTC:  op_b_d = '0;
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // manager input and stall
  // ----------------------------------------------------------------------

  // a squashed mfc neither waits nor consumes
  assign mfc_d         = val_d && op_d == OP_MFC && !squash;
  assign stall_d       = mfc_d && !from_mngr_val;
  assign from_mngr_rdy = mfc_d && !stall_w;

  // ----------------------------------------------------------------------
  // decode -> execute register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      val_x <= 1'b0;
    end else if (!stall_w) begin
      val_x <= val_d && !squash && !stall_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_w) begin
      op_a_x <= op_a_d;
      op_b_x <= op_b_d;
      inst_x <= inst_d;
      pc_x   <= pc_d;
    end
  end

  // a waiting mfc stays in decode until the manager word comes
  a_mfc_held: assert property (@(posedge clk) disable iff (rst)
    stall_d |=> (val_d && op_d == OP_MFC && $stable(inst_d)))
    else $error("waiting mfc left decode without a manager word");

endmodule

/* src/proc_execute.sv */
`timescale 1ns/10ps
/* execute stage: ALU, branch compare and redirect, plus the
   execute-to-writeback register; redirect doubles as the decode squash */

module proc_execute (
  input  logic            clk,
  input  logic            rst,
  input  proc_pkg::word_t op_a_x,
  input  proc_pkg::word_t op_b_x,
  input  proc_pkg::inst_t inst_x,
  input  proc_pkg::pc_t   pc_x,
  input  logic            val_x,
  input  logic            stall_w,
  output proc_pkg::word_t alu_x,
  output logic            redirect,
  output proc_pkg::pc_t   redirect_pc,
  output proc_pkg::word_t result_w,
  output proc_pkg::inst_t inst_w,
  output logic            val_w
);
  import proc_pkg::*;

  opcode_t op_x;
  logic    eq_x;

  assign op_x = inst_op(inst_x);

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------

  // addi, add, mfc and mtc all go through the adder
  always_comb begin
    case (op_x)
      OP_SUB:  alu_x = op_a_x - op_b_x;
      OP_AND:  alu_x = op_a_x & op_b_x;
      default: alu_x = op_a_x + op_b_x;
    endcase
  end

  // ----------------------------------------------------------------------
  // branch resolution
  // ----------------------------------------------------------------------

  assign eq_x = op_a_x == op_b_x;

  // only a valid branch may redirect
  assign redirect = val_x && ((op_x == OP_BNE && !eq_x) || (op_x == OP_BEQ && eq_x));

  // target is pc + 1 + imm7, wraps inside the store
  assign redirect_pc = pc_x + pc_t'(1) + pc_t'(sext_imm(inst_x));

  // ----------------------------------------------------------------------
  // execute -> writeback register
  // ----------------------------------------------------------------------

  // whole pipe freezes behind a waiting mtc
  always_ff @(posedge clk) begin
    if (rst) begin
      val_w <= 1'b0;
    end else if (!stall_w) begin
      val_w <= val_x;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_w) begin
      result_w <= alu_x;
      inst_w   <= inst_x;
    end
  end

endmodule

/* src/proc_writeback.sv */
`timescale 1ns/10ps
/* writeback stage: turns the executed instruction into a register write
   or a to_mngr transfer; a waiting mtc stalls every stage */

module proc_writeback (
  input  logic                clk,
  input  logic                rst,
  input  proc_pkg::word_t     result_w,
  input  proc_pkg::inst_t     inst_w,
  input  logic                val_w,
  output logic                rf_wen,
  output proc_pkg::reg_addr_t rf_waddr,
  output proc_pkg::word_t     rf_wdata,
  output logic                stall_w,
  output proc_pkg::word_t     to_mngr_msg,
  output logic                to_mngr_val,
  input  logic                to_mngr_rdy
);
  import proc_pkg::*;

  opcode_t op_w;

  assign op_w = inst_op(inst_w);

  // ----------------------------------------------------------------------
  // register write
  // ----------------------------------------------------------------------

  // r0 stays zero
  assign rf_waddr = inst_rd(inst_w);
  assign rf_wdata = result_w;
  assign rf_wen   = val_w && writes_rd(op_w) && rf_waddr != '0;

  // ----------------------------------------------------------------------
  // to_mngr port
  // ----------------------------------------------------------------------

  // mtc result is rs + 0
  assign to_mngr_msg = result_w;
  assign to_mngr_val = val_w && op_w == OP_MTC;

  // hold until the manager takes the word
  assign stall_w = to_mngr_val && !to_mngr_rdy;

  // frozen pipe must keep the offered word steady
  a_to_mngr_hold: assert property (@(posedge clk) disable iff (rst)
    (to_mngr_val && !to_mngr_rdy) |=> (to_mngr_val && $stable(to_mngr_msg)))
    else $error("to_mngr message changed before transfer");

endmodule

/* src/proc_top.sv */
`timescale 1ns/10ps
/* four-stage core: fetch, decode, execute, writeback
   program goes in through the load port during reset, data through the manager ports */

module proc_top (
  input  logic            clk,
  input  logic            rst,
  // instruction load
  input  logic            imem_wen,
  input  proc_pkg::pc_t   imem_waddr,
  input  proc_pkg::inst_t imem_wdata,
  // from manager
  input  proc_pkg::word_t from_mngr_msg,
  input  logic            from_mngr_val,
  output logic            from_mngr_rdy,
  // to manager
  output proc_pkg::word_t to_mngr_msg,
  output logic            to_mngr_val,
  input  logic            to_mngr_rdy
);
  import proc_pkg::*;

  // fetch -> decode
  inst_t     inst_d;
  pc_t       pc_d;
  logic      val_d;
  // decode -> execute
  word_t     op_a_x;
  word_t     op_b_x;
  inst_t     inst_x;
  pc_t       pc_x;
  logic      val_x;
  logic      stall_d;
  // execute -> writeback, plus bypass and redirect
  word_t     alu_x;
  logic      redirect;
  pc_t       redirect_pc;
  word_t     result_w;
  inst_t     inst_w;
  logic      val_w;
  // writeback -> decode
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      stall_w;

  // fetch halts on either stall
  proc_fetch u_fetch (
    .clk(clk), .rst(rst), .imem_wen(imem_wen), .imem_waddr(imem_waddr),
    .imem_wdata(imem_wdata), .redirect(redirect), .redirect_pc(redirect_pc),
    .stall(stall_d || stall_w), .inst_d(inst_d), .pc_d(pc_d), .val_d(val_d)
  );

  proc_decode u_decode (
    .clk(clk), .rst(rst), .inst_d(inst_d), .pc_d(pc_d), .val_d(val_d),
    .alu_x(alu_x), .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
    .squash(redirect), .stall_w(stall_w), .from_mngr_msg(from_mngr_msg),
    .from_mngr_val(from_mngr_val), .from_mngr_rdy(from_mngr_rdy), .stall_d(stall_d),
    .op_a_x(op_a_x), .op_b_x(op_b_x), .inst_x(inst_x), .pc_x(pc_x), .val_x(val_x)
  );

  proc_execute u_execute (
    .clk(clk), .rst(rst), .op_a_x(op_a_x), .op_b_x(op_b_x), .inst_x(inst_x),
    .pc_x(pc_x), .val_x(val_x), .stall_w(stall_w), .alu_x(alu_x), .redirect(redirect),
    .redirect_pc(redirect_pc), .result_w(result_w), .inst_w(inst_w), .val_w(val_w)
  );

  proc_writeback u_writeback (
    .clk(clk), .rst(rst), .result_w(result_w), .inst_w(inst_w), .val_w(val_w),
    .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .stall_w(stall_w),
    .to_mngr_msg(to_mngr_msg), .to_mngr_val(to_mngr_val), .to_mngr_rdy(to_mngr_rdy)
  );

endmodule

/* testbench/proc_tb.sv */
`timescale 1ns/10ps
/* testbench for the four-stage core: loads a short multiply program during reset,
   streams operand pairs through from_mngr and checks the four results of every pair */

module proc_tb;
  import proc_pkg::*;

  localparam int NROWS    = 12;
  localparam int N_OUT    = 4 * NROWS;
  localparam int PROG_LEN = 14;
  localparam int LIMIT    = NROWS * 200;

  logic  clk = 1'b0;
  logic  rst;
  logic  imem_wen;
  pc_t   imem_waddr;
  inst_t imem_wdata;
  word_t from_mngr_msg;
  logic  from_mngr_val;
  logic  from_mngr_rdy;
  word_t to_mngr_msg;
  logic  to_mngr_val;
  logic  to_mngr_rdy;

  // operand rows and the four results each row must give
  word_t row_a    [NROWS];
  word_t row_b    [NROWS];
  word_t row_sum  [NROWS];
  word_t row_diff [NROWS];
  word_t row_and  [NROWS];
  word_t row_prod [NROWS];
  inst_t prog     [PROG_LEN];

  int err_values;
  int err_other;
  int out_count;
  int cycles;

  proc_top dut (
    .clk(clk), .rst(rst), .imem_wen(imem_wen), .imem_waddr(imem_waddr),
    .imem_wdata(imem_wdata), .from_mngr_msg(from_mngr_msg),
    .from_mngr_val(from_mngr_val), .from_mngr_rdy(from_mngr_rdy),
    .to_mngr_msg(to_mngr_msg), .to_mngr_val(to_mngr_val), .to_mngr_rdy(to_mngr_rdy)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ----------------------------------------------------------------------
  // instruction encoding
  // ----------------------------------------------------------------------

  // add, sub, and, mtc
  function automatic inst_t r_type(opcode_t op, int rd, int rs, int rt);
    return {op, 3'(rd), 3'(rs), 3'(rt), 4'b0};
  endfunction

  // addi, bne, beq, mfc
  function automatic inst_t i_type(opcode_t op, int rd, int rs, int imm);
    return {op, 3'(rd), 3'(rs), 7'(imm)};
  endfunction

  // mfc a, mfc b, then a+b, a-b, a&b and a*b by repeated add
  task automatic build_program();
    prog[0]  = i_type(OP_MFC, 1, 0, 0);
    prog[1]  = i_type(OP_MFC, 2, 0, 0);
    prog[2]  = r_type(OP_ADD, 3, 1, 2);
    prog[3]  = r_type(OP_MTC, 0, 3, 0);
    prog[4]  = r_type(OP_SUB, 4, 1, 2);
    prog[5]  = r_type(OP_MTC, 0, 4, 0);
    prog[6]  = r_type(OP_AND, 6, 1, 2);
    prog[7]  = r_type(OP_MTC, 0, 6, 0);
    prog[8]  = i_type(OP_ADDI, 5, 0, 0);
    // loop body at 9..11
    prog[9]  = r_type(OP_ADD, 5, 5, 1);
    prog[10] = i_type(OP_ADDI, 2, 2, -1);
    prog[11] = i_type(OP_BNE, 0, 2, -3);
    prog[12] = r_type(OP_MTC, 0, 5, 0);
    // 13 + 1 - 14 wraps to the start
    prog[13] = i_type(OP_BEQ, 0, 0, -14);
  endtask

  // a, b and the four results per row, all modulo 2**16
  task automatic build_table();
    row_a    = '{16'h0005, 16'h0003, 16'h1234, 16'hffff, 16'h0000, 16'h8000,
                 16'h00ff, 16'habcd, 16'h0001, 16'h7fff, 16'h5555, 16'h0002};
    row_b    = '{16'd1, 16'd7, 16'd2, 16'd3, 16'd4, 16'd5,
                 16'd6, 16'd7, 16'd1, 16'd2, 16'd3, 16'd6};
    row_sum  = '{16'h0006, 16'h000a, 16'h1236, 16'h0002, 16'h0004, 16'h8005,
                 16'h0105, 16'habd4, 16'h0002, 16'h8001, 16'h5558, 16'h0008};
    // negative differences wrap
    row_diff = '{16'h0004, 16'hfffc, 16'h1232, 16'hfffc, 16'hfffc, 16'h7ffb,
                 16'h00f9, 16'habc6, 16'h0000, 16'h7ffd, 16'h5552, 16'hfffc};
    row_and  = '{16'h0001, 16'h0003, 16'h0000, 16'h0003, 16'h0000, 16'h0000,
                 16'h0006, 16'h0005, 16'h0001, 16'h0002, 16'h0001, 16'h0002};
    row_prod = '{16'h0005, 16'h0015, 16'h2468, 16'hfffd, 16'h0000, 16'h8000,
                 16'h05fa, 16'hb29b, 16'h0001, 16'hfffe, 16'hffff, 16'h000c};
  endtask

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------

  task automatic check_value(string name, word_t got, word_t exp);
    if (got !== exp) begin
      err_values++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("%0d value errors, %0d other errors, %0d of %0d outputs seen",
             err_values, err_other, out_count, N_OUT);
  endtask

  // results come in row order: sum, difference, and, product
  task automatic take_output(word_t msg);
    int row;
    row = out_count / 4;
    if (out_count >= N_OUT) begin
      err_other++;
      $display("output %h arrived after all %0d expected results", msg, N_OUT);
    end else begin
      case (out_count % 4)
        0:       check_value("to_mngr_msg (a+b)", msg, row_sum[row]);
        1:       check_value("to_mngr_msg (a-b)", msg, row_diff[row]);
        2:       check_value("to_mngr_msg (a&b)", msg, row_and[row]);
        default: check_value("to_mngr_msg (a*b)", msg, row_prod[row]);
      endcase
    end
    out_count++;
  endtask

  // ----------------------------------------------------------------------
  // stimulus, driven 1 ns after the rising edge
  // ----------------------------------------------------------------------

  // one word per cycle, only honored with rst high
  task automatic load_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      imem_wen   = 1'b1;
      imem_waddr = pc_t'(i);
      imem_wdata = prog[i];
      @(posedge clk);
      #1;
    end
    imem_wen = 1'b0;
  endtask

  // random idle gap, then hold msg and val until the core takes the word
  task automatic send_word(word_t w);
    int unsigned gap;
    logic        taken;
    gap = $urandom_range(0, 3);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    from_mngr_msg = w;
    from_mngr_val = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = from_mngr_rdy;
      @(posedge clk);
      #1;
    end
    from_mngr_val = 1'b0;
  endtask

  task automatic feed_inputs();
    for (int i = 0; i < NROWS; i++) begin
      send_word(row_a[i]);
      send_word(row_b[i]);
    end
  endtask

  // rdy low on about 3 cycles in 10
  task automatic drive_out_ready();
    forever begin
      to_mngr_rdy = ($urandom_range(0, 9) >= 3);
      @(posedge clk);
      #1;
    end
  endtask

  // mid-cycle both val and rdy are settled for the coming edge
  task automatic watch_outputs();
    forever begin
      @(negedge clk);
      if (to_mngr_val && to_mngr_rdy) begin
        take_output(to_mngr_msg);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(69616));
    rst           = 1'b1;
    imem_wen      = 1'b0;
    imem_waddr    = '0;
    imem_wdata    = '0;
    from_mngr_msg = '0;
    from_mngr_val = 1'b0;
    to_mngr_rdy   = 1'b0;
    err_values    = 0;
    err_other     = 0;
    out_count     = 0;
    build_table();
    build_program();
    @(posedge clk);
    #1;
    load_program();
    // core held 3 more cycles, both handshakes quiet
    repeat (3) begin
      @(negedge clk);
      check_value("from_mngr_rdy", word_t'(from_mngr_rdy), '0);
      check_value("to_mngr_val", word_t'(to_mngr_val), '0);
      @(posedge clk);
      #1;
    end
    rst = 1'b0;
    // first mfc not in decode yet
    @(negedge clk);
    check_value("from_mngr_rdy", word_t'(from_mngr_rdy), '0);
    @(posedge clk);
    #1;
    fork
      feed_inputs();
      drive_out_ready();
      watch_outputs();
    join_none
    wait (out_count >= N_OUT);
    // a duplicate would land in this window
    repeat (40) @(posedge clk);
    report_counts();
    if (err_values == 0 && err_other == 0 && out_count == N_OUT) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit, about 200 cycles per row
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, results stopped coming", cycles);
      report_counts();
      $display("test failed");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+src
src/proc_pkg.sv
src/proc_fetch.sv
src/proc_decode.sv
src/proc_execute.sv
src/proc_writeback.sv
src/proc_top.sv
testbench/proc_tb.sv

/* run.sh */
#!/bin/sh
# build the core and its testbench with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -f sources.f --top-module proc_tb -o Vproc_tb; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vproc_tb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
